// ==== src.f ====
+incdir+include
hdl/ahb_pkg.sv
hdl/mtx_pkg.sv
hdl/mtx_out_arb.sv
hdl/mtx_addr_mux.sv
hdl/mtx_data_stage.sv
hdl/mtx_out_stage.sv
verif/mtx_out_stage_properties.sv
verif/mtx_out_stage_tb.sv

// ==== Makefile ====
# Verilator build and run for the AHB matrix output stage

TOP := mtx_out_stage_tb

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): src.f hdl/*.sv verif/*.sv include/*.svh
	verilator --binary --timing --assert -Wno-fatal \
		-f src.f --top-module $(TOP) -o V$(TOP)

# Status comes from the search for the pass message
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf obj_dir

// ==== verif/mtx_out_stage_tb.sv ====
// Random-stimulus testbench for the AHB matrix output stage
// A cycle model of grant, lock and data phase is compared with the DUT every cycle
`timescale 1ns/100ps
`include "mtx_defs.svh"

module mtx_out_stage_tb;

  localparam int NUM_CYCLES = 2000;  // Random cycles after reset
  localparam int CLK_PERIOD = 10;    // ns

  logic                                       HCLK;
  logic                                       HRESETn;
  ahb_pkg::ahb_addr_t [`MTX_NUM_PORTS-1:0]    port_addr;   // Address phase per port
  logic [`MTX_NUM_PORTS-1:0][`AHB_DATA_W-1:0] port_wdata;
  logic [`MTX_NUM_PORTS-1:0]                  held_tran;
  logic                                       hreadyout;   // Slave HREADYOUT
  logic [`MTX_NUM_PORTS-1:0]                  active;
  ahb_pkg::ahb_addr_t                         slave_addr;
  logic [`AHB_DATA_W-1:0]                     hwdata;
  logic                                       hready_mux;

  integer                    seed = 98943;  // $random seed
  int                        errors = 0;
  int                        checks = 0;
  int                        lock_holds = 0;  // Accepted edges that kept a locked grant
  logic [`MTX_NUM_PORTS-1:0] lock_req;        // Sticky mastlock per port

  // ----------------------------------------
  // Reference model state
  // ----------------------------------------
  mtx_pkg::port_sel_e   m_grant;
  mtx_pkg::lock_state_e m_lock;
  mtx_pkg::port_sel_e   m_data_port;
  logic                 m_slave_sel;

  mtx_out_stage mtx_out_stage_inst (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .i_port_addr  (port_addr),
    .i_port_wdata (port_wdata),
    .i_held_tran  (held_tran),
    .i_hreadyout  (hreadyout),
    .o_active     (active),
    .o_slave_addr (slave_addr),
    .o_hwdata     (hwdata),
    .o_hready_mux (hready_mux)
  );

  initial
  begin
    HCLK = 1'b0;
    forever #(CLK_PERIOD / 2) HCLK = ~HCLK;
  end

  // Port code to bundle index with port 2 at 0
  function automatic int port_index(mtx_pkg::port_sel_e p);
    case (p)
      mtx_pkg::PORT_2 : return 0;
      mtx_pkg::PORT_3 : return 1;
      default         : return 2;
    endcase
  endfunction

  // Bundle the slave should see for the model's grant
  function automatic ahb_pkg::ahb_addr_t granted_bundle();
    if (m_grant == mtx_pkg::PORT_NONE)
      return '0;
    return port_addr[port_index(m_grant)];
  endfunction

  // Lowest-numbered requester wins
  function automatic mtx_pkg::port_sel_e priority_pick();
    if (held_tran[0] && port_addr[0].sel)
      return mtx_pkg::PORT_2;
    if (held_tran[1] && port_addr[1].sel)
      return mtx_pkg::PORT_3;
    if (held_tran[2] && port_addr[2].sel)
      return mtx_pkg::PORT_4;
    return mtx_pkg::PORT_NONE;
  endfunction

  // One rising edge of the model where stalls freeze everything
  task automatic model_step();
    ahb_pkg::ahb_addr_t cur;
    logic               hold;
    cur  = granted_bundle();
    hold = cur.mastlock & ((m_lock == mtx_pkg::LOCK_HELD) | cur.sel);
    if (!m_slave_sel || hreadyout)
    begin
      if (cur.sel && cur.trans[1] && cur.mastlock)
        m_lock = mtx_pkg::LOCK_HELD;
      else if (!cur.mastlock)
        m_lock = mtx_pkg::LOCK_IDLE;
      m_data_port = m_grant;             // Old grant moves to data phase
      m_slave_sel = cur.sel;
      if (hold)
        lock_holds++;
      else
        m_grant = priority_pick();
    end
  endtask

  task automatic report_mismatch(string name, logic [63:0] exp_val, logic [63:0] act_val);
    errors++;
    $display("Mismatch %s: expected %h, actual %h at %0t", name, exp_val, act_val, $time);
  endtask

  task automatic check_outputs();
    ahb_pkg::ahb_addr_t        exp_addr;
    logic [`MTX_NUM_PORTS-1:0] exp_active;
    logic [`AHB_DATA_W-1:0]    exp_wdata;
    logic                      exp_ready;
    exp_addr   = granted_bundle();
    exp_active = '0;
    if (m_grant != mtx_pkg::PORT_NONE)
      exp_active[port_index(m_grant)] = 1'b1;
    exp_wdata = '0;                      // No data-phase owner
    if (m_data_port != mtx_pkg::PORT_NONE)
      exp_wdata = port_wdata[port_index(m_data_port)];
    exp_ready = m_slave_sel ? hreadyout : 1'b1;
    checks++;
    assert (active === exp_active)
    else report_mismatch("active", 64'(exp_active), 64'(active));
    assert (slave_addr === exp_addr)
    else report_mismatch("slave_addr", 64'(exp_addr), 64'(slave_addr));
    assert (hwdata === exp_wdata)
    else report_mismatch("hwdata", 64'(exp_wdata), 64'(hwdata));
    assert (hready_mux === exp_ready)
    else report_mismatch("hready_mux", 64'(exp_ready), 64'(hready_mux));
  endtask

  // ----------------------------------------
  // Random stimulus
  // ----------------------------------------
  task automatic drive_inputs();
    logic [31:0] r;
    for (int i = 0; i < `MTX_NUM_PORTS; i++)
    begin
      r = $random(seed);
      held_tran[i]          = r[0];
      port_addr[i].sel      = r[2] | r[3];                 // Selected 3 in 4
      port_addr[i].trans    = ahb_pkg::htrans_e'(r[5:4]);
      port_addr[i].write    = r[6];
      port_addr[i].size     = r[9:7];
      if (lock_req[i])
        lock_req[i] = (r[11:10] != 2'b00);                 // Release about 1 in 4
      else
        lock_req[i] = (r[15:12] == 4'h0);                  // Start about 1 in 16
      port_addr[i].mastlock = lock_req[i];
      port_addr[i].addr     = $random(seed);
      port_wdata[i]         = $random(seed);
    end
    r = $random(seed);
    hreadyout = (r[1:0] != 2'b00);                         // Low about 1 in 4
  endtask

  initial
  begin
    HRESETn     = 1'b0;
    port_addr   = '0;
    port_wdata  = '0;
    held_tran   = '0;
    hreadyout   = 1'b1;
    lock_req    = '0;
    m_grant     = mtx_pkg::PORT_NONE;
    m_lock      = mtx_pkg::LOCK_IDLE;
    m_data_port = mtx_pkg::PORT_NONE;
    m_slave_sel = 1'b0;
    repeat (2) @(posedge HCLK);
    #1;
    HRESETn = 1'b1;
    @(negedge HCLK);
    assert (active === '0)
    else report_mismatch("reset_active", 64'(0), 64'(active));
    assert (slave_addr.sel === 1'b0)
    else report_mismatch("reset_sel", 64'(0), 64'(slave_addr.sel));
    assert (hready_mux === 1'b1)
    else report_mismatch("reset_hready_mux", 64'(1), 64'(hready_mux));
    check_outputs();
    for (int c = 0; c < NUM_CYCLES; c++)
    begin
      @(posedge HCLK);
      model_step();                      // Inputs still hold last cycle's values
      #1;
      drive_inputs();
      @(negedge HCLK);
      check_outputs();
    end
    assert (lock_holds > 0)
    else
    begin
      errors++;
      $display("No locked sequence ever held the grant during the run");
    end
    $display("Checks: %0d, errors: %0d, lock holds: %0d", checks, errors, lock_holds);
    if (errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

  // Watchdog ends the run after its length plus 20 cycles
  initial
  begin
    #((NUM_CYCLES + 20) * CLK_PERIOD);
    $display("Timeout: the test did not finish in time");
    $display("Result: FAILED");
    $finish;
  end

endmodule

// ==== verif/mtx_out_stage_properties.sv ====
// Concurrent checks on grant, active vector and ready of the output stage
// Bound into every mtx_out_stage instance
`timescale 1ns/100ps
`include "mtx_defs.svh"

module mtx_out_stage_properties (
  input logic                      HCLK,          // AHB clock
  input logic                      HRESETn,       // Sync reset, active low
  input logic [`MTX_NUM_PORTS-1:0] i_active,      // One-hot owner
  input mtx_pkg::port_sel_e        i_grant,       // Arbiter grant
  input logic                      i_slave_sel,   // Slave in data phase
  input logic                      i_hready_mux   // HREADYMUXM
);

  // ----------------------------------------
  // Grant and ready properties
  // ----------------------------------------
  active_onehot0 : assert property (
    @(posedge HCLK) disable iff (!HRESETn) $onehot0(i_active))
    else $error("More than one port active");

  // Stalled edge leaves the grant alone
  grant_stable_in_stall : assert property (
    @(posedge HCLK) disable iff (!HRESETn) !i_hready_mux |=> $stable(i_grant))
    else $error("Grant changed during a stall");

  ready_when_unselected : assert property (
    @(posedge HCLK) disable iff (!HRESETn) !i_slave_sel |-> i_hready_mux)
    else $error("Ready low with no slave data phase");

endmodule

bind mtx_out_stage mtx_out_stage_properties u_properties (
  .HCLK         (HCLK),
  .HRESETn      (HRESETn),
  .i_active     (o_active),
  .i_grant      (grant),
  .i_slave_sel  (u_data_stage.slave_sel),
  .i_hready_mux (o_hready_mux)
);

// ==== hdl/mtx_out_stage.sv ====
// Shared-slave output stage of the AHB matrix for input ports 2 to 4
// Top level joining arbiter, address mux and data stage
`timescale 1ns/100ps
`include "mtx_defs.svh"

module mtx_out_stage (
  input  logic                                     HCLK,          // AHB clock
  input  logic                                     HRESETn,       // Sync reset, active low
  input  ahb_pkg::ahb_addr_t [`MTX_NUM_PORTS-1:0]  i_port_addr,   // Address phase per port
  input  logic [`MTX_NUM_PORTS-1:0][`AHB_DATA_W-1:0] i_port_wdata,  // Write data per port
  input  logic [`MTX_NUM_PORTS-1:0]                i_held_tran,   // Held transfer per port
  input  logic                                     i_hreadyout,   // Slave HREADYOUT
  output logic [`MTX_NUM_PORTS-1:0]                o_active,      // One-hot owner
  output ahb_pkg::ahb_addr_t                       o_slave_addr,  // Slave address phase
  output logic [`AHB_DATA_W-1:0]                   o_hwdata,      // Slave HWDATA
  output logic                                     o_hready_mux   // HREADYMUXM
);

  // ----------------------------------------
  // Internal nets
  // ----------------------------------------
  mtx_pkg::port_sel_e grant;      // Arbiter result
  logic               hlock_arb;  // Lock hold back to arbiter

  // Producer of grants
  mtx_out_arb u_out_arb (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .i_port_addr  (i_port_addr),
    .i_held_tran  (i_held_tran),
    .i_hready_mux (o_hready_mux),
    .i_hlock_arb  (hlock_arb),
    .o_grant      (grant)
  );

  // Address-phase routing and lock tracking
  mtx_addr_mux u_addr_mux (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .i_port_addr  (i_port_addr),
    .i_grant      (grant),
    .i_hready_mux (o_hready_mux),
    .o_slave_addr (o_slave_addr),
    .o_active     (o_active),
    .o_hlock_arb  (hlock_arb)
  );

  // Data phase and ready generation
  mtx_data_stage u_data_stage (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .i_grant      (grant),
    .i_slave_sel  (o_slave_addr.sel),  // Selected HSEL
    .i_port_wdata (i_port_wdata),
    .i_hreadyout  (i_hreadyout),
    .o_hwdata     (o_hwdata),
    .o_hready_mux (o_hready_mux)
  );

endmodule

// ==== hdl/mtx_data_stage.sv ====
// Data phase of the output stage with the data-port register and HWDATA mux
// Also builds HREADYMUXM from the slave's HREADYOUT
`timescale 1ns/100ps
`include "mtx_defs.svh"

module mtx_data_stage (
  input  logic                                     HCLK,          // AHB clock
  input  logic                                     HRESETn,       // Sync reset, active low
  input  mtx_pkg::port_sel_e                       i_grant,       // Address-phase owner
  input  logic                                     i_slave_sel,   // Selected HSEL
  input  logic [`MTX_NUM_PORTS-1:0][`AHB_DATA_W-1:0] i_port_wdata,  // Write data per port
  input  logic                                     i_hreadyout,   // Slave HREADYOUT
  output logic [`AHB_DATA_W-1:0]                   o_hwdata,      // To shared slave
  output logic                                     o_hready_mux   // Transfer done
);

  mtx_pkg::port_sel_e data_port;   // Data-phase owner
  logic               slave_sel;   // Slave in data phase
  logic               hready_mux;  // Internal ready

  // ----------------------------------------
  // Data-phase registers
  // ----------------------------------------
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      data_port <= mtx_pkg::PORT_NONE;
      slave_sel <= 1'b0;
    end
    else if (hready_mux)
    begin
      data_port <= i_grant;        // Address phase moves to data phase
      slave_sel <= i_slave_sel;
    end
  end

  // Write data follows the data-phase owner
  always_comb
  begin
    case (data_port)
      mtx_pkg::PORT_2 : o_hwdata = i_port_wdata[0];
      mtx_pkg::PORT_3 : o_hwdata = i_port_wdata[1];
      mtx_pkg::PORT_4 : o_hwdata = i_port_wdata[2];
      default         : o_hwdata = '0;  // No owner
    endcase
  end

  // Slave ready only matters while it owns a data phase
  assign hready_mux   = slave_sel ? i_hreadyout : 1'b1;
  assign o_hready_mux = hready_mux;

endmodule

// ==== hdl/mtx_addr_mux.sv ====
// Routes the granted port's address phase to the shared slave
// Also decodes the active vector and tracks locked sequences
`timescale 1ns/100ps
`include "mtx_defs.svh"

module mtx_addr_mux (
  input  logic                                    HCLK,          // AHB clock
  input  logic                                    HRESETn,       // Sync reset, active low
  input  ahb_pkg::ahb_addr_t [`MTX_NUM_PORTS-1:0] i_port_addr,   // Address phase per port
  input  mtx_pkg::port_sel_e                      i_grant,       // Current grant
  input  logic                                    i_hready_mux,  // Transfer accepted
  output ahb_pkg::ahb_addr_t                      o_slave_addr,  // To shared slave
  output logic [`MTX_NUM_PORTS-1:0]               o_active,      // One-hot owner
  output logic                                    o_hlock_arb    // Lock hold to arbiter
);

  mtx_pkg::lock_state_e lock_state;       // Lock register
  mtx_pkg::lock_state_e next_lock_state;  // Pre-registered lock

  // ----------------------------------------
  // Address and active decode
  // ----------------------------------------
  always_comb
  begin
    o_slave_addr = '0;                    // Idle bus when nothing granted
    o_active     = '0;
    case (i_grant)
      mtx_pkg::PORT_2 :
      begin
        o_slave_addr = i_port_addr[0];
        o_active[0]  = 1'b1;
      end
      mtx_pkg::PORT_3 :
      begin
        o_slave_addr = i_port_addr[1];
        o_active[1]  = 1'b1;
      end
      mtx_pkg::PORT_4 :
      begin
        o_slave_addr = i_port_addr[2];
        o_active[2]  = 1'b1;
      end
      default         : ;                 // PORT_NONE keeps the zeros
    endcase
  end

  // ----------------------------------------
  // Locked-sequence tracking
  // ----------------------------------------
  // Covers a master leaving HSEL low partway through a locked sequence
  always_comb
  begin
    if (o_slave_addr.sel && o_slave_addr.trans[1] && o_slave_addr.mastlock)
      next_lock_state = mtx_pkg::LOCK_HELD;   // Locked transfer started here
    else if (!o_slave_addr.mastlock)
      next_lock_state = mtx_pkg::LOCK_IDLE;   // Lock released
    else
      next_lock_state = lock_state;
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      lock_state <= mtx_pkg::LOCK_IDLE;
    else if (i_hready_mux)
      lock_state <= next_lock_state;
  end

  // Lock masked off unless selected or already held
  assign o_hlock_arb = o_slave_addr.mastlock &
                       ((lock_state == mtx_pkg::LOCK_HELD) | o_slave_addr.sel);

endmodule

// ==== hdl/mtx_out_arb.sv ====
// Fixed-priority arbiter for the shared slave, port 2 highest
// Grant is registered on accepted edges and held through locked sequences
`timescale 1ns/100ps
`include "mtx_defs.svh"

module mtx_out_arb (
  input  logic                                    HCLK,          // AHB clock
  input  logic                                    HRESETn,       // Sync reset, active low
  input  ahb_pkg::ahb_addr_t [`MTX_NUM_PORTS-1:0] i_port_addr,   // Address phase per port
  input  logic [`MTX_NUM_PORTS-1:0]               i_held_tran,   // Held transfer per port
  input  logic                                    i_hready_mux,  // Transfer accepted
  input  logic                                    i_hlock_arb,   // Keep current grant
  output mtx_pkg::port_sel_e                      o_grant        // Registered grant
);

  logic [`MTX_NUM_PORTS-1:0] req;         // Per-port request
  mtx_pkg::port_sel_e        next_grant;  // Arbitration result
  mtx_pkg::port_sel_e        grant;       // Grant register

  // ----------------------------------------
  // Request forming
  // ----------------------------------------
  always_comb
  begin
    for (int i = 0; i < `MTX_NUM_PORTS; i++)
    begin
      req[i] = i_held_tran[i] & i_port_addr[i].sel;  // Pending and targeting us
    end
  end

  // ----------------------------------------
  // Priority pick
  // ----------------------------------------
  always_comb
  begin
    if (i_hlock_arb)
      next_grant = grant;                  // Locked owner keeps the slave
    else if (req[0])
      next_grant = mtx_pkg::PORT_2;        // Highest priority
    else if (req[1])
      next_grant = mtx_pkg::PORT_3;
    else if (req[2])
      next_grant = mtx_pkg::PORT_4;        // Lowest priority
    else
      next_grant = mtx_pkg::PORT_NONE;     // Park with no owner
  end

  // Grant register frozen while the slave stalls
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      grant <= mtx_pkg::PORT_NONE;
    else if (i_hready_mux)
      grant <= next_grant;
  end

  assign o_grant = grant;

endmodule

// ==== hdl/mtx_pkg.sv ====
// Matrix-side types for the shared-slave output stage
// Port grant code and locked-sequence state

package mtx_pkg;

  // ----------------------------------------
  // Granted input port
  // ----------------------------------------
  // PORT_NONE parks the slave with no owner
  typedef enum logic [1:0] {
    PORT_NONE = 2'd0,  // Nothing granted
    PORT_2    = 2'd1,  // Input port 2, index 0
    PORT_3    = 2'd2,  // Input port 3, index 1
    PORT_4    = 2'd3   // Input port 4, index 2
  } port_sel_e;

  // ----------------------------------------
  // Locked-sequence state
  // ----------------------------------------
  // Set once a locked transfer starts through the granted port
  typedef enum logic {
    LOCK_IDLE = 1'b0,  // No locked sequence open
    LOCK_HELD = 1'b1   // Locked sequence in progress
  } lock_state_e;

endpackage

// ==== hdl/ahb_pkg.sv ====
// AHB bus-side types shared by the matrix RTL and the testbench
// Address-phase signals travel together as one packed struct
`include "mtx_defs.svh"

package ahb_pkg;

  // ----------------------------------------
  // Transfer type
  // ----------------------------------------
  typedef enum logic [1:0] {
    IDLE   = 2'b00,  // No transfer
    BUSY   = 2'b01,  // Burst paused
    NONSEQ = 2'b10,  // First beat
    SEQ    = 2'b11   // Following beat
  } htrans_e;        // Bit 1 set means active

  // Transfer size, byte to 1024 bits
  typedef logic [`AHB_SIZE_W-1:0] hsize_t;

  // ----------------------------------------
  // Address-phase bundle, 40 bits
  // ----------------------------------------
  typedef struct packed {
    logic                   sel;       // HSEL
    logic [`AHB_ADDR_W-1:0] addr;      // HADDR
    htrans_e                trans;     // HTRANS
    logic                   write;     // HWRITE, 1 for write
    hsize_t                 size;      // HSIZE
    logic                   mastlock;  // HMASTLOCK
  } ahb_addr_t;

endpackage

// ==== include/mtx_defs.svh ====
// Bus widths and port count for the AHB matrix output stage
// Include wherever a bus or the port array is sized
`ifndef MTX_DEFS_SVH
`define MTX_DEFS_SVH

// ----------------------------------------
// AHB bus widths
// ----------------------------------------
`define AHB_ADDR_W     32   // HADDR width
`define AHB_DATA_W     32   // HWDATA width
`define AHB_SIZE_W     3    // HSIZE width

// ----------------------------------------
// Matrix connectivity
// ----------------------------------------
`define MTX_NUM_PORTS  3    // Input ports 2, 3 and 4

`endif
